//--- sim.f
verilog/aud_cfg_pkg.sv
verilog/aud_ctl_pkg.sv
verilog/mem_port_if.sv
verilog/aud_recorder.sv
verilog/aud_player.sv
verilog/mem_arbiter.sv
verilog/sample_mem.sv
verilog/aud_core.sv
test/aud_core_assert.sv
test/aud_core_checker.sv
test/aud_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the aud_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module aud_core_tb -o aud_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/aud_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

//--- test/aud_core_tb.sv
`timescale 1ns/1ns

module aud_core_tb;
    import aud_cfg_pkg::*;

    localparam int FRAME_LEN = 32;     // bit clocks per lrc frame
    localparam int N_TESTS   = 10;
    localparam int MAX_FR    = 8;

    typedef enum logic [2:0] {
        act_idle,
        act_record,
        act_pause,
        act_resume,
        act_stop,
        act_play
    } action_e;

    logic                bclk;
    logic                rst_n;
    logic                lrc;
    logic                adcdat;
    logic                rec_start;
    logic                rec_pause;
    logic                rec_stop;
    logic                play;
    logic                dacdat;
    logic [ADDR_W:0]     rec_count;
    logic                recording;
    logic                playing;

    // expected values handed to the checker
    logic                exp_clear;
    logic                exp_push;
    logic [SAMPLE_W-1:0] exp_word;
    logic                test_end;
    int                  test_id;
    logic                exp_rec;
    int                  exp_played;
    int                  n_tests;
    int                  n_errors;
    int                  model_count;  // words the recorder should hold

    action_e             tbl_act    [N_TESTS];
    int                  tbl_frames [N_TESTS];
    logic                tbl_rec    [N_TESTS];  // o_recording after the entry
    logic [SAMPLE_W-1:0] tbl_words  [N_TESTS][MAX_FR];

    aud_core aud_core_i (
        .i_bclk      (bclk),
        .i_rst_n     (rst_n),
        .i_lrc       (lrc),
        .i_adcdat    (adcdat),
        .i_rec_start (rec_start),
        .i_rec_pause (rec_pause),
        .i_rec_stop  (rec_stop),
        .i_play      (play),
        .o_dacdat    (dacdat),
        .o_rec_count (rec_count),
        .o_recording (recording),
        .o_playing   (playing)
    );

    aud_core_checker checker_i (
        .i_bclk       (bclk),
        .i_lrc        (lrc),
        .i_dacdat     (dacdat),
        .i_playing    (playing),
        .i_recording  (recording),
        .i_rec_count  (rec_count),
        .i_exp_clear  (exp_clear),
        .i_exp_push   (exp_push),
        .i_exp_word   (exp_word),
        .i_test_end   (test_end),
        .i_test_id    (test_id),
        .i_exp_rec    (exp_rec),
        .i_exp_played (exp_played),
        .o_tests      (n_tests),
        .o_errors     (n_errors)
    );

    initial begin
        bclk = 1'b0;
        forever #2 bclk = ~bclk;
    end

    task automatic tick();
        @(posedge bclk);
        #1;
    endtask

    task automatic set_entry(input int t, input action_e a, input int n, input logic rec);
        tbl_act[t]    = a;
        tbl_frames[t] = n;
        tbl_rec[t]    = rec;
        for (int f = 0; f < MAX_FR; f++) begin
            tbl_words[t][f] = SAMPLE_W'($urandom);
        end
    endtask

    // low half carries the left word msb first
    task automatic send_frames(input int t, input logic store);
        logic [SAMPLE_W-1:0] w;
        for (int f = 0; f < tbl_frames[t]; f++) begin
            w        = tbl_words[t][f];
            exp_word = w;
            exp_push = store;
            for (int i = 0; i < FRAME_LEN; i++) begin
                lrc    = (i >= SAMPLE_W);
                adcdat = (i < SAMPLE_W) ? w[SAMPLE_W-1-i] : 1'b0;
                tick();
                exp_push = 1'b0;
            end
        end
    endtask

    // last write lands a variable time after its final bit
    task automatic wait_count(input int n);
        int guard;
        guard = 0;
        while (rec_count != (ADDR_W + 1)'(n) && guard < FRAME_LEN) begin
            tick();
            guard++;
        end
    endtask

    task automatic run_entry(input int t);
        int played;
        played = 0;
        case (tbl_act[t])
            act_record, act_resume: begin
                if (tbl_act[t] == act_record) begin
                    model_count = 0;   // start from idle clears the take
                    exp_clear   = 1'b1;
                end
                rec_start = 1'b1;
                tick();
                rec_start = 1'b0;
                exp_clear = 1'b0;
                tick();                // recorder sees lrc high here
                send_frames(t, 1'b1);
                model_count += tbl_frames[t];
                wait_count(model_count);
            end
            act_pause: begin
                rec_pause = 1'b1;
                tick();
                rec_pause = 1'b0;
                tick();
                send_frames(t, 1'b0);  // dropped by the recorder
            end
            act_stop: begin
                rec_stop = 1'b1;
                tick();
                rec_stop = 1'b0;
                tick();
                send_frames(t, 1'b0);
            end
            act_play: begin
                play = 1'b1;
                tick();
                play = 1'b0;
                tick();                // first fetch
                send_frames(t, 1'b0);
                played = model_count;
            end
            default: send_frames(t, 1'b0);
        endcase
        repeat (4) tick();
        test_id    = t;
        exp_rec    = tbl_rec[t];
        exp_played = played;
        test_end   = 1'b1;
        tick();
        test_end   = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        lrc         = 1'b1;
        adcdat      = 1'b0;
        rec_start   = 1'b0;
        rec_pause   = 1'b0;
        rec_stop    = 1'b0;
        play        = 1'b0;
        exp_clear   = 1'b0;
        exp_push    = 1'b0;
        exp_word    = '0;
        test_end    = 1'b0;
        test_id     = 0;
        exp_rec     = 1'b0;
        exp_played  = 0;
        model_count = 0;
        void'($urandom(32'h5b6b3760));

        set_entry(0, act_idle,   0, 1'b0);   // reset values
        set_entry(1, act_play,   2, 1'b0);   // nothing recorded yet
        set_entry(2, act_record, 4, 1'b1);
        set_entry(3, act_pause,  2, 1'b0);
        set_entry(4, act_resume, 3, 1'b1);
        set_entry(5, act_stop,   0, 1'b0);
        set_entry(6, act_play,   7, 1'b0);
        set_entry(7, act_record, 3, 1'b1);   // fresh take
        set_entry(8, act_stop,   0, 1'b0);
        set_entry(9, act_play,   3, 1'b0);

        repeat (4) @(posedge bclk);
        #1;
        rst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end
        repeat (4) tick();
        $display("%0d tests run, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int total;
        total = 0;
        #1;
        for (int t = 0; t < N_TESTS; t++) begin
            total += tbl_frames[t];
        end
        #((total * FRAME_LEN + 256) * 4);
        $display("timeout: the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- test/aud_core_checker.sv
`timescale 1ns/1ns

module aud_core_checker (
    input  logic                             i_bclk,
    input  logic                             i_lrc,
    input  logic                             i_dacdat,
    input  logic                             i_playing,
    input  logic                             i_recording,
    input  logic [aud_cfg_pkg::ADDR_W:0]     i_rec_count,
    input  logic                             i_exp_clear,
    input  logic                             i_exp_push,
    input  logic [aud_cfg_pkg::SAMPLE_W-1:0] i_exp_word,
    input  logic                             i_test_end,
    input  int                               i_test_id,
    input  logic                             i_exp_rec,
    input  int                               i_exp_played,
    output int                               o_tests,
    output int                               o_errors
);
    import aud_cfg_pkg::*;

    logic [SAMPLE_W-1:0] exp_q [$];     // recorded words in order
    logic [SAMPLE_W-1:0] got;
    logic                lrc_prev  = 1'b1;
    logic                lrc_last  = 1'b1;
    logic                lrc_edge;
    logic                slot_on   = 1'b0;
    logic                playing_q = 1'b0;
    int                  pos       = 0;   // edge number inside the half frame
    int                  play_idx  = 0;
    int                  played    = 0;
    int                  tests     = 0;
    int                  errors    = 0;
    int                  err_mark  = 0;

    assign o_tests  = tests;
    assign o_errors = errors;

    task automatic check_word(input logic right);
        if (play_idx >= exp_q.size()) begin
            $display("playback sent a word beyond the recorded count");
            errors++;
        end else if (got !== exp_q[play_idx]) begin
            $display("Fail o_dacdat %s word %0d: got %h, expected %h",
                     right ? "right" : "left", play_idx, got, exp_q[play_idx]);
            errors++;
        end
        if (right) begin
            play_idx++;
            played++;
        end
    endtask

    task automatic finish_test();
        tests++;
        if (i_rec_count !== (ADDR_W + 1)'(exp_q.size())) begin
            $display("Fail o_rec_count: got %h, expected %h", i_rec_count, exp_q.size());
            errors++;
        end
        if (i_recording !== i_exp_rec) begin
            $display("Fail o_recording: got %h, expected %h", i_recording, i_exp_rec);
            errors++;
        end
        if (i_playing !== 1'b0 || i_dacdat !== 1'b0) begin
            $display("Fail o_playing/o_dacdat: got %h/%h, expected 0/0", i_playing, i_dacdat);
            errors++;
        end
        if (played != i_exp_played) begin
            $display("Fail o_dacdat word count: got %h, expected %h", played, i_exp_played);
            errors++;
        end
        $display("test %0d: %s", i_test_id, (errors == err_mark) ? "pass" : "fail");
        played   = 0;
        err_mark = errors;
    endtask

    // lrc changes after the rising edge, so keep the value each edge saw
    always @(negedge i_bclk) begin
        lrc_edge = lrc_prev;
        lrc_prev = i_lrc;
        pos      = (lrc_edge != lrc_last) ? 1 : pos + 1;
        lrc_last = lrc_edge;

        if (i_exp_clear) exp_q.delete();
        if (i_exp_push) exp_q.push_back(i_exp_word);

        if (i_playing && !playing_q) play_idx = 0;
        if (!i_playing && playing_q && play_idx != exp_q.size()) begin
            $display("Fail o_playing: dropped after %h words, expected %h",
                     play_idx, exp_q.size());
            errors++;
        end
        playing_q = i_playing;

        if (pos == 1) slot_on = i_playing;
        if (slot_on && pos <= SAMPLE_W) begin
            got[SAMPLE_W - pos] = i_dacdat;   // bit 16-j after edge j
            if (pos == SAMPLE_W) check_word(lrc_edge);
        end

        if (i_test_end) finish_test();
    end

endmodule

//--- test/aud_core_assert.sv
`timescale 1ns/1ns

module aud_core_assert (
    input logic i_bclk,
    input logic i_rst_n,
    input logic i_rec_req,
    input logic i_rec_gnt,
    input logic i_play_req,
    input logic i_play_gnt
);

    // one owner per cycle
    one_grant: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        !(i_rec_gnt && i_play_gnt))
        else $error("both memory grants high");

    rec_gnt_req: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        i_rec_gnt |-> i_rec_req)
        else $error("recorder grant without a request");

    play_gnt_req: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        i_play_gnt |-> i_play_req)
        else $error("player grant without a request");

    play_served: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        (i_play_req && !i_rec_req) |-> i_play_gnt)
        else $error("player request not granted with the recorder quiet");

endmodule

bind mem_arbiter aud_core_assert aud_core_assert_i (
    .i_bclk     (i_bclk),
    .i_rst_n    (i_rst_n),
    .i_rec_req  (rec.req),
    .i_rec_gnt  (rec.gnt),
    .i_play_req (play.req),
    .i_play_gnt (play.gnt)
);

//--- verilog/aud_core.sv
`timescale 1ns/1ns

module aud_core (
    input  logic                         i_bclk,
    input  logic                         i_rst_n,
    input  logic                         i_lrc,
    input  logic                         i_adcdat,
    input  logic                         i_rec_start,
    input  logic                         i_rec_pause,
    input  logic                         i_rec_stop,
    input  logic                         i_play,
    output logic                         o_dacdat,
    output logic [aud_cfg_pkg::ADDR_W:0] o_rec_count,
    output logic                         o_recording,
    output logic                         o_playing
);
    import aud_cfg_pkg::*;

    logic                mem_we;
    logic [ADDR_W-1:0]   mem_addr;
    logic [SAMPLE_W-1:0] mem_wdata;
    logic [SAMPLE_W-1:0] mem_rdata;
    logic [ADDR_W:0]     rec_count;

    mem_port_if rec_port ();
    mem_port_if play_port ();

    aud_recorder aud_recorder_i (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_adcdat    (i_adcdat),
        .i_start     (i_rec_start),
        .i_pause     (i_rec_pause),
        .i_stop      (i_rec_stop),
        .mem         (rec_port.client),
        .o_count     (rec_count),
        .o_recording (o_recording)
    );

    // player reads back 0 .. rec_count-1
    aud_player aud_player_i (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_lrc     (i_lrc),
        .i_play    (i_play),
        .i_count   (rec_count),
        .mem       (play_port.client),
        .o_dacdat  (o_dacdat),
        .o_playing (o_playing)
    );

    mem_arbiter mem_arbiter_i (
        .i_bclk      (i_bclk),
        .i_rst_n     (i_rst_n),
        .rec         (rec_port.arbiter),
        .play        (play_port.arbiter),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    sample_mem sample_mem_i (
        .i_bclk  (i_bclk),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    assign o_rec_count = rec_count;

endmodule

//--- verilog/sample_mem.sv
`timescale 1ns/1ns

module sample_mem (
    input  logic                             i_bclk,
    input  logic                             i_we,
    input  logic [aud_cfg_pkg::ADDR_W-1:0]   i_addr,
    input  logic [aud_cfg_pkg::SAMPLE_W-1:0] i_wdata,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0] o_rdata
);
    import aud_cfg_pkg::*;

    logic [SAMPLE_W-1:0] mem [MEM_DEPTH];

    // single port, read returns the old word on a write
    always_ff @(posedge i_bclk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];     // one cycle latency
    end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                           i_bclk,
    input  logic                           i_rst_n,
    mem_port_if.arbiter                    rec,
    mem_port_if.arbiter                    play,
    output logic                           o_mem_we,
    output logic [aud_cfg_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [aud_cfg_pkg::SAMPLE_W-1:0] o_mem_wdata,
    input  logic [aud_cfg_pkg::SAMPLE_W-1:0] i_mem_rdata
);
    import aud_ctl_pkg::*;

    mem_owner_e owner;
    mem_owner_e owner_q;    // who accessed at the last edge

    // recorder first, it cannot wait
    always_comb begin
        owner = own_none;
        if (rec.req) begin
            owner = own_rec;
        end else if (play.req) begin
            owner = own_play;
        end
    end

    assign rec.gnt  = (owner == own_rec);
    assign play.gnt = (owner == own_play);

    always_comb begin
        case (owner)
            own_rec: begin
                o_mem_we    = rec.we;
                o_mem_addr  = rec.addr;
                o_mem_wdata = rec.wdata;
            end
            own_play: begin
                o_mem_we    = play.we;
                o_mem_addr  = play.addr;
                o_mem_wdata = play.wdata;
            end
            default: begin
                o_mem_we    = 1'b0;
                o_mem_addr  = '0;
                o_mem_wdata = '0;
            end
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            owner_q <= own_none;
        end else begin
            owner_q <= owner;
        end
    end

    // read data back to whoever read
    assign rec.rdata  = (owner_q == own_rec)  ? i_mem_rdata : '0;
    assign play.rdata = (owner_q == own_play) ? i_mem_rdata : '0;

endmodule

//--- verilog/aud_player.sv
`timescale 1ns/1ns

module aud_player (
    input  logic                         i_bclk,
    input  logic                         i_rst_n,
    input  logic                         i_lrc,
    input  logic                         i_play,
    input  logic [aud_cfg_pkg::ADDR_W:0] i_count,
    mem_port_if.client                   mem,
    output logic                         o_dacdat,
    output logic                         o_playing
);
    import aud_cfg_pkg::*;
    import aud_ctl_pkg::*;

    play_state_e         state;
    logic [BITCNT_W-1:0] bit_cnt;
    logic [ADDR_W-1:0]   rd_addr;
    logic [ADDR_W:0]     next_addr;
    logic [ADDR_W:0]     last_cnt;    // count latched at the play pulse
    logic                rd_req;
    logic                rd_pend;     // rdata valid this cycle
    logic                last_word;
    logic                load_word;
    logic [SAMPLE_W-1:0] nxt_word;
    logic [SAMPLE_W-1:0] cur_word;
    logic [SAMPLE_W-1:0] fetched;

    assign next_addr = {1'b0, rd_addr} + 1'b1;
    assign fetched   = rd_pend ? mem.rdata : nxt_word;
    assign load_word = (state == play_wait_l) && !last_word && !i_lrc;

    assign mem.req   = rd_req;
    assign mem.we    = 1'b0;          // read only client
    assign mem.addr  = rd_addr;
    assign mem.wdata = '0;

    assign o_playing = (state != play_idle);

    always_ff @(posedge i_bclk) begin
        if (rd_pend) begin
            nxt_word <= mem.rdata;
        end
        if (load_word) begin
            cur_word <= fetched;
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= play_idle;
            bit_cnt   <= '0;
            rd_addr   <= '0;
            last_cnt  <= '0;
            rd_req    <= 1'b0;
            rd_pend   <= 1'b0;
            last_word <= 1'b0;
            o_dacdat  <= 1'b0;
        end else begin
            rd_pend <= rd_req && mem.gnt;
            if (rd_req && mem.gnt) begin
                rd_req <= 1'b0;
            end

            case (state)
                play_idle: begin
                    if (i_play && i_count != '0) begin
                        state     <= play_fetch;
                        rd_addr   <= '0;
                        rd_req    <= 1'b1;
                        last_cnt  <= i_count;
                        last_word <= 1'b0;
                    end
                end
                play_fetch: begin
                    if (mem.gnt) state <= play_wait_l;
                end
                play_wait_l: begin
                    if (last_word) begin
                        state    <= play_idle;   // both slots of the final word sent
                        o_dacdat <= 1'b0;
                    end else if (!i_lrc) begin
                        o_dacdat <= fetched[SAMPLE_W-1];
                        bit_cnt  <= BITCNT_W'(SAMPLE_W - 2);
                        state    <= play_left;
                    end
                end
                play_left: begin
                    o_dacdat <= cur_word[bit_cnt];
                    bit_cnt  <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) state <= play_wait_r;
                end
                play_wait_r: begin
                    if (i_lrc) begin
                        o_dacdat <= cur_word[SAMPLE_W-1];  // same word again
                        bit_cnt  <= BITCNT_W'(SAMPLE_W - 2);
                        state    <= play_right;
                        // prefetch while the right slot runs
                        if (next_addr < last_cnt) begin
                            rd_addr <= next_addr[ADDR_W-1:0];
                            rd_req  <= 1'b1;
                        end else begin
                            last_word <= 1'b1;
                        end
                    end
                end
                play_right: begin
                    o_dacdat <= cur_word[bit_cnt];
                    bit_cnt  <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) state <= play_wait_l;
                end
                default: state <= play_idle;
            endcase
        end
    end

endmodule

//--- verilog/aud_recorder.sv
`timescale 1ns/1ns

module aud_recorder (
    input  logic                         i_bclk,
    input  logic                         i_rst_n,
    input  logic                         i_lrc,
    input  logic                         i_adcdat,
    input  logic                         i_start,
    input  logic                         i_pause,
    input  logic                         i_stop,
    mem_port_if.client                   mem,
    output logic [aud_cfg_pkg::ADDR_W:0] o_count,
    output logic                         o_recording
);
    import aud_cfg_pkg::*;
    import aud_ctl_pkg::*;

    rec_state_e          state;
    logic [BITCNT_W-1:0] bit_cnt;
    logic [SAMPLE_W-1:0] shift_q;
    logic                wr_pend;     // finished word waiting for the port
    logic                last_bit;
    logic                wr_done;

    assign last_bit = (bit_cnt == BITCNT_W'(SAMPLE_W - 1));
    assign wr_done  = wr_pend && mem.gnt;

    assign mem.req   = wr_pend;
    assign mem.we    = wr_pend;
    assign mem.addr  = o_count[ADDR_W-1:0];
    assign mem.wdata = shift_q;

    assign o_recording = (state == rec_wait) || (state == rec_shift);

    // left slot deserializer, msb first
    always_ff @(posedge i_bclk) begin
        if (state == rec_shift && !i_lrc) begin
            shift_q <= {shift_q[SAMPLE_W-2:0], i_adcdat};
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= rec_idle;
            bit_cnt <= '0;
            wr_pend <= 1'b0;
            o_count <= '0;
        end else begin
            if (wr_done) begin
                wr_pend <= 1'b0;
                o_count <= o_count + 1'b1;
            end

            if (i_stop) begin
                state <= rec_idle;
            end else if (i_pause) begin
                if (state != rec_idle) begin
                    state <= rec_pause;      // partial word is dropped
                end
            end else begin
                case (state)
                    rec_idle: begin
                        if (i_start) begin
                            state   <= rec_wait;
                            bit_cnt <= '0;
                            o_count <= '0;   // fresh take
                        end
                    end
                    rec_wait: begin
                        // no new slot until the last word is written
                        if (i_lrc && (!wr_pend || mem.gnt)) begin
                            state   <= rec_shift;
                            bit_cnt <= '0;
                        end
                    end
                    rec_shift: begin
                        if (!i_lrc) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                state   <= rec_wait;
                                wr_pend <= 1'b1;
                            end
                        end
                    end
                    rec_pause: begin
                        if (i_start) begin
                            state   <= rec_wait;     // resume at current count
                            bit_cnt <= '0;
                        end
                    end
                    default: state <= rec_idle;
                endcase
            end

            // memory full
            if (wr_done && o_count == (ADDR_W + 1)'(MEM_DEPTH - 1)) begin
                state <= rec_idle;
            end
        end
    end

endmodule

//--- verilog/mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if ();
    import aud_cfg_pkg::*;

    logic                req;      // level, held until gnt
    logic                we;
    logic [ADDR_W-1:0]   addr;
    logic [SAMPLE_W-1:0] wdata;
    logic                gnt;      // same-cycle answer to req
    logic [SAMPLE_W-1:0] rdata;    // valid the cycle after a read grant

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

//--- verilog/aud_ctl_pkg.sv
package aud_ctl_pkg;

    // recorder FSM
    typedef enum logic [1:0] {
        rec_idle,
        rec_wait,       // armed, waiting for lrc high
        rec_shift,      // collecting the left slot
        rec_pause
    } rec_state_e;

    // player FSM
    typedef enum logic [2:0] {
        play_idle,
        play_fetch,     // first word only
        play_wait_l,
        play_left,
        play_wait_r,
        play_right
    } play_state_e;

    // who holds the memory port this cycle
    typedef enum logic [1:0] {
        own_none,
        own_rec,
        own_play
    } mem_owner_e;

endpackage

//--- verilog/aud_cfg_pkg.sv
package aud_cfg_pkg;

    // codec word size, left channel only on the record side
    localparam int SAMPLE_W  = 16;

    // counts bit positions 0..15 inside one slot
    localparam int BITCNT_W  = 4;

    // on-chip sample store
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 256;     // 2**ADDR_W words

endpackage
